// File: list.f
dehaze_pkg.sv
window_filter.sv
delay_line.sv
transmission_estimator.sv
scene_recovery.sv
dehaze_top.sv
tb_dehaze.sv

// File: tb_dehaze.sv
// Testbench for dehaze_top with omega shift 4 and floor 26; all checks sample on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_dehaze;

    localparam int OMEGA_SHIFT       = 4;
    localparam int T_MIN             = 26;
    localparam int LATENCY           = 6;
    localparam int MAX_CYCLES        = 2000;
    localparam int unsigned SEED     = 32'h8ecd_a73b;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               input_valid = 1'b0;
    dehaze_pkg::pixel_t win [9];
    dehaze_pkg::chan_t  a_r, a_g, a_b;
    dehaze_pkg::inv_t   inv_a_r, inv_a_g, inv_a_b;
    dehaze_pkg::chan_t  out_r, out_g, out_b;
    logic               output_valid;

    // Pending results, each entry is {flat, light, expected}
    logic [48:0] exp_q [$];
    logic [23:0] exp_head;
    logic [23:0] head_light;
    logic        head_flat;
    int          exp_count = 0;

    int errors = 0;
    int err_mark = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycles = 0;

    dehaze_top #(.OMEGA_SHIFT(OMEGA_SHIFT), .T_MIN(T_MIN)) DUT (
        .clk(clk), .rst(rst), .input_valid(input_valid),
        .win_0(win[0]), .win_1(win[1]), .win_2(win[2]),
        .win_3(win[3]), .win_4(win[4]), .win_5(win[5]),
        .win_6(win[6]), .win_7(win[7]), .win_8(win[8]),
        .a_r(a_r), .a_g(a_g), .a_b(a_b),
        .inv_a_r(inv_a_r), .inv_a_g(inv_a_g), .inv_a_b(inv_a_b),
        .out_r(out_r), .out_g(out_g), .out_b(out_b),
        .output_valid(output_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: results still missing after %0d clock cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ============================================================
    // Checks
    // ============================================================

    a_reset_quiet: assert property (@(negedge clk) rst |-> !output_valid ##1 !output_valid)
        else begin
            errors++;
            $display("At %0t output_valid was high during reset or the cycle after it", $time);
        end

    a_latency: assert property (@(negedge clk) disable iff (rst)
        output_valid == $past(input_valid, LATENCY))
        else begin
            errors++;
            $display("At %0t output_valid did not follow input_valid by %0d cycles",
                     $time, LATENCY);
        end

    a_no_orphan: assert property (@(negedge clk) disable iff (rst)
        output_valid |-> exp_count != 0)
        else begin
            errors++;
            $display("At %0t a result came out with no window waiting for it", $time);
        end

    a_value: assert property (@(negedge clk) disable iff (rst)
        (output_valid && exp_count != 0) |-> {out_r, out_g, out_b} == exp_head)
        else begin
            errors++;
            $display("** Error at %0t: pixel %h, expected %h",
                     $time, {out_r, out_g, out_b}, $sampled(exp_head));
        end

    a_flat: assert property (@(negedge clk) disable iff (rst)
        (output_valid && exp_count != 0 && head_flat) |-> {out_r, out_g, out_b} == head_light)
        else begin
            errors++;
            $display("** Error at %0t: flat window gave %h, light is %h",
                     $time, {out_r, out_g, out_b}, $sampled(head_light));
        end

    function void refresh_head();
        if (exp_q.size() != 0) begin
            {head_flat, head_light, exp_head} = exp_q[0];
        end else begin
            {head_flat, head_light, exp_head} = '0;
        end
        exp_count = exp_q.size();
    endfunction

    // Retire the head once its result has been checked
    always @(negedge clk) begin
        if (!rst && output_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    // ============================================================
    // Reference model
    // ============================================================

    // Channel 0 is red
    function automatic int lane(input dehaze_pkg::pixel_t p, input int c);
        return int'(p[16-8*c +: 8]);
    endfunction

    function automatic logic [23:0] model_pixel();
        int sm [3];
        int lt [3];
        int iv [3];
        int dark, scaled, haze, t, rc, d, mag, r;
        logic [23:0] res;
        lt[0] = a_r;
        lt[1] = a_g;
        lt[2] = a_b;
        iv[0] = inv_a_r;
        iv[1] = inv_a_g;
        iv[2] = inv_a_b;
        for (int c = 0; c < 3; c++) begin
            sm[c] = (lane(win[0], c) + lane(win[2], c) + lane(win[6], c) + lane(win[8], c)
                   + 2 * (lane(win[1], c) + lane(win[3], c) + lane(win[5], c) + lane(win[7], c))
                   + 4 * lane(win[4], c)) >> 4;
        end
        // Strict compare keeps the earlier channel on a tie
        dark = 0;
        if (sm[1] < sm[dark]) dark = 1;
        if (sm[2] < sm[dark]) dark = 2;
        scaled = iv[dark] - (iv[dark] >> OMEGA_SHIFT);
        haze = (sm[dark] * scaled) >> 8;
        if (haze > 256) haze = 256;
        t = 256 - haze;
        if (t < T_MIN) t = T_MIN;
        rc = 65536 / t;
        if (rc > 65535) rc = 65535;
        for (int c = 0; c < 3; c++) begin
            d = lane(win[4], c) - lt[c];
            mag = (((d < 0) ? -d : d) * rc) >> 8;
            if (mag > 255) mag = 255;
            r = (d >= 0) ? lt[c] + mag : lt[c] - mag;
            if (r < 0) r = 0;
            if (r > 255) r = 255;
            res[16-8*c +: 8] = 8'(r);
        end
        return res;
    endfunction

    // ============================================================
    // Stimulus helpers
    // ============================================================

    task automatic send_window(input bit flat);
        input_valid = 1'b1;
        exp_q.push_back({flat, a_r, a_g, a_b, model_pixel()});
        refresh_head();
        @(posedge clk);
        #2;
        input_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Inverse is 65536 / light, lights must be 2 or more
    task automatic set_light(input int r, input int g, input int b);
        a_r = 8'(r);
        a_g = 8'(g);
        a_b = 8'(b);
        inv_a_r = 16'(65536 / r);
        inv_a_g = 16'(65536 / g);
        inv_a_b = 16'(65536 / b);
    endtask

    task automatic fill_window(input dehaze_pkg::pixel_t p);
        for (int i = 0; i < 9; i++) begin
            win[i] = p;
        end
    endtask

    // Mode 1 gray, mode 2 red equals green, mode 3 green equals blue
    task automatic random_window(input int mode);
        dehaze_pkg::pixel_t p;
        set_light(16 + $urandom % 240, 16 + $urandom % 240, 16 + $urandom % 240);
        for (int i = 0; i < 9; i++) begin
            p = 24'($urandom);
            case (mode)
                1: p = {3{p[7:0]}};
                2: p[15:8] = p[23:16];
                3: p[7:0] = p[15:8];
                default: ;
            endcase
            win[i] = p;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            pass_count++;
            $display("Test %s: passed", name);
        end else begin
            fail_count++;
            $display("Test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        int k;
        void'($urandom(SEED));
        input_valid = 1'b0;
        fill_window('0);
        a_r = '0;
        a_g = '0;
        a_b = '0;
        inv_a_r = '0;
        inv_a_g = '0;
        inv_a_b = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        idle(3);
        finish_test("reset");

        set_light(200, 180, 160);
        fill_window(24'h405060);
        send_window(1'b0);
        wait_drain();
        finish_test("latency");

        for (k = 0; k < 4; k++) begin
            set_light(2 + $urandom % 254, 2 + $urandom % 254, 2 + $urandom % 254);
            fill_window({a_r, a_g, a_b});
            send_window(1'b1);
        end
        wait_drain();
        finish_test("flat window");

        // Bright surround saturates the haze, dark centre pulls below zero
        set_light(200, 200, 200);
        inv_a_r = 16'd400;
        inv_a_g = 16'd400;
        inv_a_b = 16'd400;
        fill_window(24'hffffff);
        win[4] = 24'h0a0a0a;
        send_window(1'b0);
        win[4] = 24'hff0a80;
        send_window(1'b0);
        // Centre just off the light exposes the floored reciprocal unclamped
        win[4] = 24'hc9c7c4;
        send_window(1'b0);
        wait_drain();
        finish_test("floor and clamp");

        for (k = 0; k < 250; k++) begin
            random_window(k % 4);
            send_window(1'b0);
        end
        wait_drain();
        finish_test("random");

        for (k = 0; k < 150; k++) begin
            random_window(k % 4);
            send_window(1'b0);
            if ($urandom % 3 == 0) begin
                idle(1 + $urandom % 2);
            end
        end
        wait_drain();
        finish_test("throughput");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dehaze_top.sv
// Dehaze pipeline, fixed 6-cycle latency, no back-pressure, one window accepted per cycle
`timescale 1ns/1ps
`default_nettype none

module dehaze_top #(
    parameter int OMEGA_SHIFT = dehaze_pkg::OMEGA_SHIFT_DEF,
    parameter int T_MIN       = dehaze_pkg::T_MIN_DEF
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               input_valid,
    input  wire dehaze_pkg::pixel_t win_0,
    input  wire dehaze_pkg::pixel_t win_1,
    input  wire dehaze_pkg::pixel_t win_2,
    input  wire dehaze_pkg::pixel_t win_3,
    input  wire dehaze_pkg::pixel_t win_4,
    input  wire dehaze_pkg::pixel_t win_5,
    input  wire dehaze_pkg::pixel_t win_6,
    input  wire dehaze_pkg::pixel_t win_7,
    input  wire dehaze_pkg::pixel_t win_8,
    input  wire dehaze_pkg::chan_t  a_r,
    input  wire dehaze_pkg::chan_t  a_g,
    input  wire dehaze_pkg::chan_t  a_b,
    input  wire dehaze_pkg::inv_t   inv_a_r,
    input  wire dehaze_pkg::inv_t   inv_a_g,
    input  wire dehaze_pkg::inv_t   inv_a_b,
    output dehaze_pkg::chan_t       out_r,
    output dehaze_pkg::chan_t       out_g,
    output dehaze_pkg::chan_t       out_b,
    output logic                    output_valid
);

    dehaze_pkg::chan_t  f_r;
    dehaze_pkg::chan_t  f_g;
    dehaze_pkg::chan_t  f_b;
    logic               f_valid;
    logic [47:0]        inv_d;      // inverses, one cycle behind
    dehaze_pkg::recip_t recip;
    logic               recip_valid;
    logic [47:0]        side_d;     // centre pixel and lights, four cycles behind

    // ============================================================
    // Smoothing, 1 cycle
    // ============================================================

    window_filter u_filter (
        .clk(clk), .rst(rst), .in_valid(input_valid),
        .win_0(win_0), .win_1(win_1), .win_2(win_2),
        .win_3(win_3), .win_4(win_4), .win_5(win_5),
        .win_6(win_6), .win_7(win_7), .win_8(win_8),
        .f_r(f_r), .f_g(f_g), .f_b(f_b), .f_valid(f_valid)
    );

    delay_line #(.WIDTH(48), .DEPTH(1)) inv_delay (
        .clk(clk), .rst(rst),
        .din({inv_a_r, inv_a_g, inv_a_b}),
        .dout(inv_d)
    );

    // ============================================================
    // Transmission, 3 cycles; side data waits 1 + 3
    // ============================================================

    transmission_estimator #(.OMEGA_SHIFT(OMEGA_SHIFT), .T_MIN(T_MIN)) u_trans (
        .clk(clk), .rst(rst), .in_valid(f_valid),
        .f_r(f_r), .f_g(f_g), .f_b(f_b),
        .inv_a_r(inv_d[47:32]), .inv_a_g(inv_d[31:16]), .inv_a_b(inv_d[15:0]),
        .recip(recip), .recip_valid(recip_valid)
    );

    delay_line #(.WIDTH(48), .DEPTH(4)) side_delay (
        .clk(clk), .rst(rst),
        .din({win_4, a_r, a_g, a_b}),
        .dout(side_d)
    );

    // ============================================================
    // Recovery, 2 cycles, owns the output registers
    // ============================================================

    scene_recovery u_recover (
        .clk(clk), .rst(rst), .in_valid(recip_valid),
        .recip(recip), .centre(side_d[47:24]),
        .a_r(side_d[23:16]), .a_g(side_d[15:8]), .a_b(side_d[7:0]),
        .out_r(out_r), .out_g(out_g), .out_b(out_b),
        .output_valid(output_valid)
    );

endmodule

`default_nettype wire

// File: scene_recovery.sv
// Two-stage recovery; recip is Q8.8 and the magnitude saturates at 255 before the add
`timescale 1ns/1ps
`default_nettype none

module scene_recovery (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               in_valid,
    input  wire dehaze_pkg::recip_t recip,
    input  wire dehaze_pkg::pixel_t centre,
    input  wire dehaze_pkg::chan_t  a_r,
    input  wire dehaze_pkg::chan_t  a_g,
    input  wire dehaze_pkg::chan_t  a_b,
    output dehaze_pkg::chan_t       out_r,
    output dehaze_pkg::chan_t       out_g,
    output dehaze_pkg::chan_t       out_b,
    output logic                    output_valid
);

    // Channel index 0 is red, 2 is blue
    dehaze_pkg::chan_t  light [3];
    dehaze_pkg::chan_t  pix   [3];
    logic signed [8:0]  diff  [3];
    dehaze_pkg::chan_t  absd  [3];
    logic [23:0]        prod  [3];
    dehaze_pkg::chan_t  mag   [3];

    dehaze_pkg::chan_t  s1_mag   [3];
    dehaze_pkg::chan_t  s1_light [3];
    logic [2:0]         s1_neg;
    logic               s1_valid;

    logic signed [10:0] res   [3];
    dehaze_pkg::chan_t  out_q [3];

    assign light[0] = a_r;
    assign light[1] = a_g;
    assign light[2] = a_b;

    // ============================================================
    // Stage 1: sign and scaled magnitude
    // ============================================================

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            pix[c]  = centre[23-8*c -: 8];
            diff[c] = $signed({1'b0, pix[c]}) - $signed({1'b0, light[c]});
            absd[c] = diff[c][8] ? 8'(-diff[c]) : diff[c][7:0];
            prod[c] = absd[c] * recip;
            mag[c]  = (prod[c][23:8] > 16'd255) ? 8'd255 : prod[c][15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < 3; c++) begin
                s1_mag[c]   <= '0;
                s1_light[c] <= '0;
            end
            s1_neg   <= '0;
            s1_valid <= 1'b0;
        end else begin
            for (int c = 0; c < 3; c++) begin
                s1_mag[c]   <= mag[c];
                s1_light[c] <= light[c];
                s1_neg[c]   <= diff[c][8];
            end
            s1_valid <= in_valid;
        end
    end

    // ============================================================
    // Stage 2: move away from the light, clamp
    // ============================================================

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            res[c] = s1_neg[c]
                ? $signed({3'b000, s1_light[c]}) - $signed({3'b000, s1_mag[c]})
                : $signed({3'b000, s1_light[c]}) + $signed({3'b000, s1_mag[c]});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < 3; c++) begin
                out_q[c] <= '0;
            end
            output_valid <= 1'b0;
        end else begin
            for (int c = 0; c < 3; c++) begin
                out_q[c] <= dehaze_pkg::clamp_chan(res[c]);
            end
            output_valid <= s1_valid;
        end
    end

    assign out_r = out_q[0];
    assign out_g = out_q[1];
    assign out_b = out_q[2];

    // Only compare once both looked-back cycles lie after reset
    a_two_cycle: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) |-> (output_valid == $past(in_valid, 2)));

endmodule

`default_nettype wire

// File: transmission_estimator.sv
// Three-stage transmission path; T_MIN must be 1..256 and OMEGA_SHIFT below 16
`timescale 1ns/1ps
`default_nettype none

module transmission_estimator #(
    parameter int OMEGA_SHIFT = dehaze_pkg::OMEGA_SHIFT_DEF,
    parameter int T_MIN       = dehaze_pkg::T_MIN_DEF
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              in_valid,
    input  wire dehaze_pkg::chan_t f_r,
    input  wire dehaze_pkg::chan_t f_g,
    input  wire dehaze_pkg::chan_t f_b,
    input  wire dehaze_pkg::inv_t  inv_a_r,
    input  wire dehaze_pkg::inv_t  inv_a_g,
    input  wire dehaze_pkg::inv_t  inv_a_b,
    output dehaze_pkg::recip_t     recip,
    output logic                   recip_valid
);

    // ============================================================
    // Stage 1: dark channel and omega scaling
    // ============================================================

    dehaze_pkg::chan_sel_e dark_sel;
    dehaze_pkg::chan_t     dark_min;
    dehaze_pkg::inv_t      dark_inv;
    dehaze_pkg::chan_t     s1_min;
    dehaze_pkg::inv_t      s1_inv;
    logic                  s1_valid;

    // Ties resolve to red, then green
    always_comb begin
        if (f_r <= f_g && f_r <= f_b) begin
            dark_sel = dehaze_pkg::CH_RED;
        end else if (f_g <= f_b) begin
            dark_sel = dehaze_pkg::CH_GREEN;
        end else begin
            dark_sel = dehaze_pkg::CH_BLUE;
        end

        case (dark_sel)
            dehaze_pkg::CH_RED: begin
                dark_min = f_r;
                dark_inv = inv_a_r;
            end
            dehaze_pkg::CH_GREEN: begin
                dark_min = f_g;
                dark_inv = inv_a_g;
            end
            default: begin
                dark_min = f_b;
                dark_inv = inv_a_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_min   <= '0;
            s1_inv   <= '0;
            s1_valid <= 1'b0;
        end else begin
            s1_min   <= dark_min;
            s1_inv   <= dark_inv - (dark_inv >> OMEGA_SHIFT);
            s1_valid <= in_valid;
        end
    end

    // ============================================================
    // Stage 2: haze estimate and floored transmission
    // ============================================================

    logic [23:0]        haze_prod;
    dehaze_pkg::trans_t haze;
    dehaze_pkg::trans_t trans_raw;
    dehaze_pkg::trans_t s2_trans;
    logic               s2_valid;

    always_comb begin
        haze_prod = s1_min * s1_inv;
        // Q8.8 estimate, capped at 1.0
        haze      = (haze_prod[23:8] > 16'd256) ? 9'd256 : haze_prod[16:8];
        trans_raw = 9'd256 - haze;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_trans <= '0;
            s2_valid <= 1'b0;
        end else begin
            s2_trans <= (trans_raw < T_MIN) ? dehaze_pkg::trans_t'(T_MIN) : trans_raw;
            s2_valid <= s1_valid;
        end
    end

    // ============================================================
    // Stage 3: reciprocal
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            recip       <= '0;
            recip_valid <= 1'b0;
        end else begin
            recip       <= dehaze_pkg::recip_of(s2_trans);
            recip_valid <= s2_valid;
        end
    end

    a_trans_floor: assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> (s2_trans >= T_MIN));

endmodule

`default_nettype wire

// File: delay_line.sv
// Plain shift register for side data; DEPTH must be at least 1, every stage loads each cycle
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 1
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [WIDTH-1:0] din,
    output logic      [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            // Shift towards the tail
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: window_filter.sv
// Fixed 1-2-1 kernel only, result truncated by the divide by 16; one cycle, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module window_filter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               in_valid,
    input  wire dehaze_pkg::pixel_t win_0,
    input  wire dehaze_pkg::pixel_t win_1,
    input  wire dehaze_pkg::pixel_t win_2,
    input  wire dehaze_pkg::pixel_t win_3,
    input  wire dehaze_pkg::pixel_t win_4,
    input  wire dehaze_pkg::pixel_t win_5,
    input  wire dehaze_pkg::pixel_t win_6,
    input  wire dehaze_pkg::pixel_t win_7,
    input  wire dehaze_pkg::pixel_t win_8,
    output dehaze_pkg::chan_t       f_r,
    output dehaze_pkg::chan_t       f_g,
    output dehaze_pkg::chan_t       f_b,
    output logic                    f_valid
);

    // Kernel sum per byte lane, lane 2 is red, max 16 * 255
    logic [11:0] lane_sum [3];
    logic [23:0] f_q;

    genvar g;
    generate
        for (g = 0; g < 3; g++) begin : g_lane
            // Corners x1, edges x2, centre x4
            assign lane_sum[g] =
                  12'(win_0[g*8 +: 8]) + 12'(win_2[g*8 +: 8])
                + 12'(win_6[g*8 +: 8]) + 12'(win_8[g*8 +: 8])
                + ((12'(win_1[g*8 +: 8]) + 12'(win_3[g*8 +: 8])
                  + 12'(win_5[g*8 +: 8]) + 12'(win_7[g*8 +: 8])) << 1)
                + (12'(win_4[g*8 +: 8]) << 2);
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            f_q     <= '0;
            f_valid <= 1'b0;
        end else begin
            f_q     <= {lane_sum[2][11:4], lane_sum[1][11:4], lane_sum[0][11:4]};
            f_valid <= in_valid;
        end
    end

    assign f_r = f_q[23:16];
    assign f_g = f_q[15:8];
    assign f_b = f_q[7:0];

    // Valid must be clean once out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(f_valid));

endmodule

`default_nettype wire

// File: dehaze_pkg.sv
// Shared dehazing types and helpers; recip_of expects a transmission of at least 1 to be useful
`default_nettype none

package dehaze_pkg;

    // ============================================================
    // Data types
    // ============================================================

    // Packed RGB, red in the top byte
    typedef logic [23:0] pixel_t;

    // One colour channel or one light value
    typedef logic [7:0] chan_t;

    // Q0.16 inverse atmospheric light
    typedef logic [15:0] inv_t;

    // Q0.8 transmission, 256 is 1.0
    typedef logic [8:0] trans_t;

    // Q8.8 reciprocal of the transmission
    typedef logic [15:0] recip_t;

    // Dark channel, listed in tie-break order
    typedef enum logic [1:0] {
        CH_RED,
        CH_GREEN,
        CH_BLUE
    } chan_sel_e;

    // ============================================================
    // Defaults
    // ============================================================

    localparam int OMEGA_SHIFT_DEF = 4;    // omega = 15/16
    localparam int T_MIN_DEF       = 26;   // roughly 0.1 in Q0.8
    localparam int LATENCY         = 6;    // input_valid to output_valid

    // 65536 / t, saturated to 16 bits
    function automatic recip_t recip_of(input trans_t t);
        logic [16:0] q;
        if (t == '0) begin
            q = 17'h1ffff;
        end else begin
            q = 17'd65536 / t;
        end
        return (q > 17'd65535) ? 16'hffff : q[15:0];
    endfunction

    // Limit a signed recovery result to a channel value
    function automatic chan_t clamp_chan(input logic signed [10:0] v);
        if (v < 11'sd0) begin
            return 8'd0;
        end
        if (v > 11'sd255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

endpackage

`default_nettype wire
